/* hdl/fb_pkg.sv */
/* Framebuffer geometry, command opcodes, the framebuffer address union
   and the structs passed between the command front end blocks. */
package fb_pkg;

    localparam int ROW_BITS        = 8;    // rows addressed by one byte.
    localparam int COL_BITS        = 10;
    localparam int COL_BYTES       = 2;    // column bytes in a command, low byte first.
    localparam int BYTES_PER_PIXEL = 3;
    localparam int PIX_BITS        = 2;    // component index width.
    localparam int FB_ADDR_BITS    = ROW_BITS + COL_BITS + PIX_BITS;

    localparam logic [7:0] OPC_WRITE_PIXEL = 8'h01;
    localparam logic [7:0] OPC_FILL_ROW    = 8'h02;

    typedef logic [ROW_BITS-1:0] row_t;
    typedef logic [COL_BITS-1:0] col_t;
    typedef logic [PIX_BITS-1:0] pix_t;

    // row is the most significant field of the framebuffer address
    typedef struct packed {
        row_t row;
        col_t col;
        pix_t pixel;
    } fb_addr_fields_t;

    // handlers fill in the fields, the bus side reads the flat word
    typedef union packed {
        fb_addr_fields_t           fields;
        logic [FB_ADDR_BITS-1:0]   flat;
    } fb_addr_u;

    // one framebuffer write request from a command handler
    typedef struct packed {
        logic       valid;
        fb_addr_u   addr;
        logic [7:0] data;
    } fb_req_t;

    // one argument byte from the dispatcher
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } cmd_byte_t;

endpackage

/* hdl/cmd_dispatch.sv */
/* Host command byte slave: opcode decode, handler selection and
   forwarding of argument bytes paced by the handler's byte_ready. */
module cmd_dispatch
    import fb_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [7:0] dat_i,
    output logic       ack,
    output cmd_byte_t  px_byte,
    output cmd_byte_t  fill_byte,
    input  logic       px_byte_ready,
    input  logic       fill_byte_ready,
    input  logic       px_done,
    input  logic       fill_done
);

    typedef enum logic {ST_IDLE, ST_FORWARD} disp_state_t;

    disp_state_t state;
    logic        sel_fill;      // 1 selects fill-row, 0 selects write-pixel.
    logic        px_valid;
    logic        fill_valid;
    logic [7:0]  byte_q;
    logic        req_seen;
    logic        sel_ready;
    logic        sel_done;

    assign req_seen  = cyc && stb && !ack;   // a new host cycle, not yet acked.
    assign sel_ready = sel_fill ? fill_byte_ready : px_byte_ready;
    assign sel_done  = sel_fill ? fill_done : px_done;

    assign px_byte   = '{valid: px_valid, data: byte_q};
    assign fill_byte = '{valid: fill_valid, data: byte_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            sel_fill   <= 1'b0;
            ack        <= 1'b0;
            px_valid   <= 1'b0;
            fill_valid <= 1'b0;
        end else begin
            ack        <= 1'b0;
            px_valid   <= 1'b0;
            fill_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_seen) begin
                        ack <= 1'b1;                  // unknown opcodes end here.
                        if (we && dat_i == OPC_WRITE_PIXEL) begin
                            sel_fill <= 1'b0;
                            state    <= ST_FORWARD;
                        end else if (we && dat_i == OPC_FILL_ROW) begin
                            sel_fill <= 1'b1;
                            state    <= ST_FORWARD;
                        end
                    end
                end
                ST_FORWARD: begin
                    if (sel_done) begin
                        state <= ST_IDLE;
                    end else if (req_seen && !we) begin
                        ack <= 1'b1;                  // reads are not forwarded.
                    end else if (req_seen && sel_ready) begin
                        ack        <= 1'b1;
                        px_valid   <= !sel_fill;
                        fill_valid <= sel_fill;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_seen) begin
            byte_q <= dat_i;
        end
    end

endmodule

/* hdl/cmd_write_pixel.sv */
/* Write-pixel handler: captures row, little-endian column and colour
   bytes, and issues one framebuffer write per component. */
module cmd_write_pixel
    import fb_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  cmd_byte_t cmd,
    output logic      byte_ready,
    output fb_req_t   req,
    input  logic      req_ready,
    output logic      done
);

    typedef enum logic [1:0] {ST_ROW, ST_COL, ST_PIXEL, ST_DONE} px_state_t;

    px_state_t              state;
    logic [1:0]             col_idx;
    logic [COL_BYTES*8-1:0] col_buf;
    logic [COL_BYTES*8-1:0] col_shift;
    fb_addr_u               addr_q;
    logic [7:0]             data_q;
    logic                   req_valid;

    // column bytes arrive low first, so shift each one in from the top
    assign col_shift = {cmd.data, col_buf[COL_BYTES*8-1:8]};

    assign byte_ready = (state != ST_DONE) && !req_valid;
    assign req        = '{valid: req_valid, addr: addr_q, data: data_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_DONE;        // settles into row capture next cycle.
            col_idx   <= '0;
            req_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_ROW: begin
                    if (cmd.valid) begin
                        addr_q.fields.row <= row_t'(cmd.data);
                        col_idx           <= '0;
                        state             <= ST_COL;
                    end
                end
                ST_COL: begin
                    if (cmd.valid) begin
                        col_buf <= col_shift;
                        col_idx <= col_idx + 2'd1;
                        if (col_idx == 2'(COL_BYTES - 1)) begin
                            addr_q.fields.col   <= col_t'(col_shift);   // upper bits dropped.
                            addr_q.fields.pixel <= pix_t'(BYTES_PER_PIXEL - 1);
                            state               <= ST_PIXEL;
                        end
                    end
                end
                ST_PIXEL: begin
                    if (cmd.valid) begin
                        req_valid <= 1'b1;
                        data_q    <= cmd.data;
                    end
                    if (req_valid && req_ready) begin
                        req_valid <= 1'b0;
                        if (addr_q.fields.pixel == '0) begin
                            done  <= 1'b1;          // last component handed over.
                            state <= ST_DONE;
                        end else begin
                            addr_q.fields.pixel <= addr_q.fields.pixel - 1'b1;
                        end
                    end
                end
                ST_DONE: begin
                    state <= ST_ROW;
                end
            endcase
        end
    end

endmodule

/* hdl/cmd_fill_row.sv */
/* Fill-row handler: captures row, start column, pixel count and colour,
   then writes the colour over a run of consecutive columns. */
module cmd_fill_row
    import fb_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  cmd_byte_t cmd,
    output logic      byte_ready,
    output fb_req_t   req,
    input  logic      req_ready,
    output logic      done
);

    typedef enum logic [2:0] {
        ST_ROW, ST_COL, ST_COUNT, ST_COLOUR, ST_ISSUE, ST_DONE
    } fill_state_t;

    fill_state_t                     state;
    logic [1:0]                      col_idx;
    logic [COL_BYTES*8-1:0]          col_buf;
    logic [COL_BYTES*8-1:0]          col_shift;
    logic [7:0]                      count_q;    // pixels still to write.
    logic [BYTES_PER_PIXEL-1:0][7:0] colour_q;
    fb_addr_u                        addr_q;
    logic                            req_valid;

    assign col_shift  = {cmd.data, col_buf[COL_BYTES*8-1:8]};
    assign byte_ready = (state == ST_ROW) || (state == ST_COL) ||
                        (state == ST_COUNT) || (state == ST_COLOUR);
    // the pixel field picks the colour byte for the current component
    assign req = '{valid: req_valid, addr: addr_q, data: colour_q[addr_q.fields.pixel]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_DONE;
            col_idx   <= '0;
            req_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_ROW: if (cmd.valid) begin
                    addr_q.fields.row <= row_t'(cmd.data);
                    col_idx           <= '0;
                    state             <= ST_COL;
                end
                ST_COL: if (cmd.valid) begin
                    col_buf <= col_shift;
                    col_idx <= col_idx + 2'd1;
                    if (col_idx == 2'(COL_BYTES - 1)) begin
                        addr_q.fields.col <= col_t'(col_shift);
                        state             <= ST_COUNT;
                    end
                end
                ST_COUNT: if (cmd.valid) begin
                    count_q             <= cmd.data;
                    addr_q.fields.pixel <= pix_t'(BYTES_PER_PIXEL - 1);  // colour slot.
                    state               <= ST_COLOUR;
                end
                ST_COLOUR: if (cmd.valid) begin
                    colour_q[addr_q.fields.pixel] <= cmd.data;
                    if (addr_q.fields.pixel == '0) begin
                        addr_q.fields.pixel <= pix_t'(BYTES_PER_PIXEL - 1);
                        if (count_q == 8'd0) begin
                            done  <= 1'b1;           // empty run, nothing to write.
                            state <= ST_DONE;
                        end else begin
                            req_valid <= 1'b1;
                            state     <= ST_ISSUE;
                        end
                    end else begin
                        addr_q.fields.pixel <= addr_q.fields.pixel - 1'b1;
                    end
                end
                ST_ISSUE: if (req_ready) begin
                    if (addr_q.fields.pixel != '0) begin
                        addr_q.fields.pixel <= addr_q.fields.pixel - 1'b1;
                    end else if (count_q == 8'd1) begin
                        req_valid <= 1'b0;
                        done      <= 1'b1;
                        state     <= ST_DONE;
                    end else begin
                        count_q             <= count_q - 8'd1;
                        addr_q.fields.col   <= addr_q.fields.col + 1'b1;   // next pixel.
                        addr_q.fields.pixel <= pix_t'(BYTES_PER_PIXEL - 1);
                    end
                end
                ST_DONE: state <= ST_ROW;
                default: state <= ST_DONE;
            endcase
        end
    end

endmodule

/* hdl/fb_write_merger.sv */
/* Write merger: grants one handler request at a time, write-pixel first,
   and runs a Wishbone classic write cycle for it. */
module fb_write_merger
    import fb_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  fb_req_t                 px_req,
    input  fb_req_t                 fill_req,
    output logic                    px_req_ready,
    output logic                    fill_req_ready,
    output logic                    fb_cyc,
    output logic                    fb_stb,
    output logic                    fb_we,
    output logic [FB_ADDR_BITS-1:0] fb_adr,
    output logic [7:0]              fb_dat_o,
    input  logic                    fb_ack
);

    logic       busy;       // a framebuffer cycle is open.
    fb_addr_u   addr_q;
    logic [7:0] data_q;

    // requests are only taken while no bus cycle is open
    assign px_req_ready   = !busy;
    assign fill_req_ready = !busy && !px_req.valid;   // write-pixel wins.

    assign fb_cyc   = busy;
    assign fb_stb   = busy;
    assign fb_we    = busy;
    assign fb_adr   = addr_q.flat;
    assign fb_dat_o = data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (fb_ack) begin
                busy <= 1'b0;                 // cyc and stb fall next cycle.
            end
        end else if (px_req.valid || fill_req.valid) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            if (px_req.valid) begin
                addr_q <= px_req.addr;
                data_q <= px_req.data;
            end else begin
                addr_q <= fill_req.addr;
                data_q <= fill_req.data;
            end
        end
    end

endmodule

/* hdl/display_cmd_top.sv */
/* Display command front end: dispatcher, write-pixel and fill-row
   handlers, and the framebuffer write merger. */
module display_cmd_top
    import fb_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [7:0]              dat_i,
    output logic                    ack,
    output logic                    fb_cyc,
    output logic                    fb_stb,
    output logic                    fb_we,
    output logic [FB_ADDR_BITS-1:0] fb_adr,
    output logic [7:0]              fb_dat_o,
    input  logic                    fb_ack
);

    cmd_byte_t px_byte;
    cmd_byte_t fill_byte;
    logic      px_byte_ready;
    logic      fill_byte_ready;
    logic      px_done;
    logic      fill_done;
    fb_req_t   px_req;
    fb_req_t   fill_req;
    logic      px_req_ready;
    logic      fill_req_ready;

    cmd_dispatch u_dispatch (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .dat_i(dat_i), .ack(ack),
        .px_byte(px_byte), .fill_byte(fill_byte), .px_byte_ready(px_byte_ready),
        .fill_byte_ready(fill_byte_ready), .px_done(px_done), .fill_done(fill_done)
    );

    cmd_write_pixel u_write_pixel (
        .clk(clk), .reset(reset), .cmd(px_byte), .byte_ready(px_byte_ready),
        .req(px_req), .req_ready(px_req_ready), .done(px_done)
    );

    cmd_fill_row u_fill_row (
        .clk(clk), .reset(reset), .cmd(fill_byte), .byte_ready(fill_byte_ready),
        .req(fill_req), .req_ready(fill_req_ready), .done(fill_done)
    );

    fb_write_merger u_merger (
        .clk(clk), .reset(reset), .px_req(px_req), .fill_req(fill_req),
        .px_req_ready(px_req_ready), .fill_req_ready(fill_req_ready),
        .fb_cyc(fb_cyc), .fb_stb(fb_stb), .fb_we(fb_we), .fb_adr(fb_adr),
        .fb_dat_o(fb_dat_o), .fb_ack(fb_ack)
    );

endmodule

/* testbench/tb_display_cmd.sv */
/* Testbench for the display command front end: random host commands, a framebuffer
   model with random acknowledge delay, and a reference queue of expected writes. */
module tb_display_cmd
    import fb_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HOST_TIMEOUT  = 200;     // cycles allowed for one host ack.
    localparam int DRAIN_TIMEOUT = 5000;
    localparam int NUM_CMDS      = 60;

    logic                    clk;
    logic                    reset;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [7:0]              dat_i;
    logic                    ack;
    logic                    fb_cyc;
    logic                    fb_stb;
    logic                    fb_we;
    logic [FB_ADDR_BITS-1:0] fb_adr;
    logic [7:0]              fb_dat_o;
    logic                    fb_ack;

    int                      seed = 61215;
    int                      mismatch_errors = 0;
    int                      other_errors = 0;
    int                      writes_seen = 0;
    logic                    host_stuck = 1'b0;   // set once the host side times out.
    logic [FB_ADDR_BITS-1:0] exp_adr [$];     // expected writes, oldest first.
    logic [7:0]              exp_dat [$];
    logic [7:0]              fb_mem [0:(1<<FB_ADDR_BITS)-1];
    logic [7:0]              ref_mem [logic [FB_ADDR_BITS-1:0]];   // expected final image.

    display_cmd_top UUT (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .dat_i(dat_i), .ack(ack),
        .fb_cyc(fb_cyc), .fb_stb(fb_stb), .fb_we(fb_we), .fb_adr(fb_adr),
        .fb_dat_o(fb_dat_o), .fb_ack(fb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    task automatic finish_run();
        $display("writes checked %0d, mismatches %0d, other errors %0d",
                 writes_seen, mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // queue one expected write and note it in the reference image
    task automatic expect_write(input logic [FB_ADDR_BITS-1:0] adr, input logic [7:0] dat);
        exp_adr.push_back(adr);
        exp_dat.push_back(dat);
        ref_mem[adr] = dat;
    endtask

    // compare one framebuffer write with the head of the expected queue
    task automatic record_write(input logic [FB_ADDR_BITS-1:0] adr, input logic [7:0] dat);
        logic [FB_ADDR_BITS-1:0] want_adr;
        logic [7:0]              want_dat;
        writes_seen++;
        if (exp_adr.size() == 0) begin
            other_errors++;
            $display("unexpected framebuffer write at %0t ns, address %h data %h",
                     $time, adr, dat);
        end else begin
            want_adr = exp_adr.pop_front();
            want_dat = exp_dat.pop_front();
            if (adr !== want_adr) begin
                mismatch_errors++;
                $display("MISMATCH at %0t ns: address %h, expected %h", $time, adr, want_adr);
            end
            if (dat !== want_dat) begin
                mismatch_errors++;
                $display("MISMATCH at %0t ns: data %h at %h, expected %h",
                         $time, dat, adr, want_dat);
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] b, input logic w);
        int waited;
        if (host_stuck) begin
            return;
        end
        @(posedge clk);
        #1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = w;
        dat_i = b;
        waited = 0;
        while (!ack && waited < HOST_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        cyc = 1'b0;                          // stb stays low for the cycle after ack.
        stb = 1'b0;
        we  = 1'b0;
        if (!ack) begin
            other_errors++;
            host_stuck = 1'b1;
            $display("host byte %h was not acknowledged within %0d cycles", b, HOST_TIMEOUT);
        end
    endtask

    // colour[0] is sent first and lands on component index 2
    task automatic write_pixel(input logic [7:0] row, input logic [7:0] col_lo,
                               input logic [7:0] col_hi, input logic [2:0][7:0] colour);
        logic [9:0] col;
        col = {col_hi[1:0], col_lo};         // little endian, upper bits dropped.
        for (int k = 0; k < 3; k++) begin
            expect_write({row, col, 2'(2 - k)}, colour[k]);
        end
        send_byte(OPC_WRITE_PIXEL, 1'b1);
        send_byte(row, 1'b1);
        send_byte(col_lo, 1'b1);
        send_byte(col_hi, 1'b1);
        for (int k = 0; k < 3; k++) begin
            send_byte(colour[k], 1'b1);
        end
    endtask

    task automatic fill_row(input logic [7:0] row, input logic [7:0] col_lo,
                            input logic [7:0] col_hi, input logic [7:0] count,
                            input logic [2:0][7:0] colour);
        logic [9:0] col;
        col = {col_hi[1:0], col_lo};
        for (int i = 0; i < count; i++) begin
            for (int k = 0; k < 3; k++) begin
                expect_write({row, 10'(col + i), 2'(2 - k)}, colour[k]);
            end
        end
        send_byte(OPC_FILL_ROW, 1'b1);
        send_byte(row, 1'b1);
        send_byte(col_lo, 1'b1);
        send_byte(col_hi, 1'b1);
        send_byte(count, 1'b1);
        for (int k = 0; k < 3; k++) begin
            send_byte(colour[k], 1'b1);
        end
    endtask

    // framebuffer slave, acks each strobe after 0 to 3 wait cycles
    initial begin : fb_model
        int delay;
        fb_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (fb_stb) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                    if (!(fb_cyc && fb_stb && fb_we)) begin
                        other_errors++;
                        $display("framebuffer write cycle dropped before fb_ack at %0t ns", $time);
                    end
                end
                if (fb_we) begin
                    fb_mem[fb_adr] = fb_dat_o;      // memory only takes write cycles.
                end
                record_write(fb_adr, fb_dat_o);
                fb_ack = 1'b1;
                @(posedge clk);
                #1;
                fb_ack = 1'b0;
                if (fb_cyc || fb_stb) begin
                    other_errors++;
                    $display("framebuffer cycle still open after fb_ack at %0t ns", $time);
                end
            end
        end
    end

    initial begin : stimulus
        logic [2:0][7:0] colour;
        logic [7:0]      opc;
        int              kind;
        int              waited;
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        dat_i = 8'h00;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        if (ack || fb_cyc || fb_stb) begin
            mismatch_errors++;
            $display("MISMATCH at %0t ns: ack, fb_cyc or fb_stb high after reset", $time);
        end

        colour = {8'h33, 8'h22, 8'h11};
        write_pixel(8'h05, 8'h34, 8'hff, colour);    // column 0x334.
        fill_row(8'h07, 8'h10, 8'h00, 8'd0, colour);  // empty run.
        send_byte(8'h00, 1'b1);
        send_byte(8'hff, 1'b1);
        send_byte(8'h5a, 1'b0);                       // host read, ignored.
        write_pixel(8'h09, 8'hff, 8'h01, colour);

        for (int n = 0; n < NUM_CMDS; n++) begin
            kind   = $unsigned($random(seed)) % 6;
            colour = {rand_byte(), rand_byte(), rand_byte()};
            case (kind)
                0, 1: write_pixel(rand_byte(), rand_byte(), rand_byte(), colour);
                2, 3: fill_row(rand_byte(), rand_byte(), rand_byte(),
                               8'($unsigned($random(seed)) % 9), colour);
                4: begin
                    opc = rand_byte();
                    if (opc == OPC_WRITE_PIXEL || opc == OPC_FILL_ROW) begin
                        opc = opc | 8'h80;
                    end
                    send_byte(opc, 1'b1);
                end
                default: send_byte(rand_byte(), 1'b0);
            endcase
        end

        waited = 0;
        while ((exp_adr.size() != 0 || fb_cyc) && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        repeat (10) @(posedge clk);                   // catch stray writes.
        if (exp_adr.size() != 0) begin
            other_errors++;
            $display("%0d expected framebuffer writes never arrived", exp_adr.size());
        end
        foreach (ref_mem[a]) begin
            if (fb_mem[a] !== ref_mem[a]) begin
                mismatch_errors++;
                $display("MISMATCH at %0t ns: framebuffer %h holds %h, expected %h",
                         $time, a, fb_mem[a], ref_mem[a]);
            end
        end
        finish_run();
    end

endmodule

/* vlog.f */
hdl/fb_pkg.sv
hdl/cmd_dispatch.sv
hdl/cmd_write_pixel.sv
hdl/cmd_fill_row.sv
hdl/fb_write_merger.sv
hdl/display_cmd_top.sv
testbench/tb_display_cmd.sv

/* run_sim.sh */
#!/bin/bash
# Build the testbench with Verilator, run it and look for the pass message.
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_display_cmd -f vlog.f -o tb_display_cmd
out=$(./obj_dir/tb_display_cmd)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
